// ==== source/xbar_config.svh ====
`ifndef XBAR_CONFIG_SVH
`define XBAR_CONFIG_SVH

// Number of push flows, one destination ID each
`define XBAR_NUM_PUSH 4

// Number of pop flows, must fit in the 2-bit destination ID
`define XBAR_NUM_POP 4

// Payload width in bits
`define XBAR_WIDTH 16

`endif

// ==== source/xbarPkg.sv ====
`default_nettype none

`include "xbar_config.svh"

package xbarPkg;

  // ----------------------------------------------------------------------
  // Plain vectors
  // ----------------------------------------------------------------------

  // Transferred data word
  typedef logic [`XBAR_WIDTH-1:0] payloadT;

  // Binary index of the target pop flow
  typedef logic [1:0] destIdT;

  // One bit per push flow, a row of the request or grant matrix
  typedef logic [`XBAR_NUM_PUSH-1:0] flowMaskT;

  // ----------------------------------------------------------------------
  // Per-flow structs
  // ----------------------------------------------------------------------

  // Content presented on one push flow
  typedef struct packed {
    payloadT payload;
    destIdT  destId;
  } pushFlitT;

  // State of one pop output register
  typedef struct packed {
    logic    valid;
    payloadT payload;
  } popFlitT;

endpackage

`default_nettype wire

// ==== source/xbarDestDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

// Destination decode
// Builds the request matrix from push valid and destination IDs
// Row index is the pop flow, column index is the push flow
module xbarDestDecode
  import xbarPkg::*;
(
  input  wire flowMaskT                         pushValid,
  input  wire pushFlitT [`XBAR_NUM_PUSH-1:0]    pushFlit,
  output flowMaskT      [`XBAR_NUM_POP-1:0]     request
);

  // ----------------------------------------------------------------------
  // Request matrix
  // ----------------------------------------------------------------------

  always_comb begin
    for (int j = 0; j < `XBAR_NUM_POP; j++) begin
      for (int i = 0; i < `XBAR_NUM_PUSH; i++) begin
        // Push i asks for pop j only while valid and aimed at j
        request[j][i] = pushValid[i] && (pushFlit[i].destId == destIdT'(j));
      end
    end
  end

  // Note that an invalid push never raises a request,
  // so every downstream grant and pushReady stays low with it
  // Destination ID is taken as is, all codes map to a pop flow

endmodule

`default_nettype wire

// ==== source/xbarArbBank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

// Arbiter bank
// One fixed-priority arbiter per pop flow
// Lowest-indexed push flow has the highest priority
module xbarArbBank
  import xbarPkg::*;
(
  input  wire flowMaskT [`XBAR_NUM_POP-1:0] request,
  input  wire logic     [`XBAR_NUM_POP-1:0] canGrant,
  output flowMaskT      [`XBAR_NUM_POP-1:0] grant
);

  // ----------------------------------------------------------------------
  // Per pop flow arbitration
  // ----------------------------------------------------------------------

  for (genvar j = 0; j < `XBAR_NUM_POP; j++) begin : genArb

    // Lowest set request bit of this row
    flowMaskT lowestReq;

    // Two's complement trick isolates the lowest set bit
    assign lowestReq = request[j] & (~request[j] + flowMaskT'(1));

    // Grant only when the pop register can take a new word
    assign grant[j] = canGrant[j] ? lowestReq : '0;

  end

  // No priority state to update
  // Each row carries at most one grant bit,
  // while one push may still be granted in several rows only
  // if its request appeared there, which the decoder rules out

endmodule

`default_nettype wire

// ==== source/xbarPopStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

// Pop stage
// Output muxes, one-entry pop registers and push ready fold
module xbarPopStage
  import xbarPkg::*;
(
  input  wire                                    clk,
  input  wire                                    rstN,
  input  wire pushFlitT [`XBAR_NUM_PUSH-1:0]     pushFlit,
  input  wire flowMaskT [`XBAR_NUM_POP-1:0]      grant,
  input  wire logic     [`XBAR_NUM_POP-1:0]      popReady,
  output logic          [`XBAR_NUM_POP-1:0]      canGrant,
  output flowMaskT                               pushReady,
  output logic          [`XBAR_NUM_POP-1:0]      popValid,
  output payloadT       [`XBAR_NUM_POP-1:0]      popData
);

  // One register per pop flow
  popFlitT [`XBAR_NUM_POP-1:0] popReg;

  // Muxed payload and load strobe per pop flow
  payloadT [`XBAR_NUM_POP-1:0] selData;
  logic    [`XBAR_NUM_POP-1:0] anyGrant;

  // ----------------------------------------------------------------------
  // Can-grant
  // ----------------------------------------------------------------------

  // Empty register, or one that unloads on this edge
  always_comb begin
    for (int j = 0; j < `XBAR_NUM_POP; j++) begin
      canGrant[j] = !popReg[j].valid || popReady[j];
    end
  end

  // ----------------------------------------------------------------------
  // Output muxes
  // ----------------------------------------------------------------------

  // One-hot AND-OR select over the push flows
  always_comb begin
    for (int j = 0; j < `XBAR_NUM_POP; j++) begin
      selData[j]  = '0;
      anyGrant[j] = |grant[j];
      for (int i = 0; i < `XBAR_NUM_PUSH; i++) begin
        selData[j] = selData[j] | ({`XBAR_WIDTH{grant[j][i]}} & pushFlit[i].payload);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Pop registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rstN) begin
      popReg <= '0;
    end else begin
      for (int j = 0; j < `XBAR_NUM_POP; j++) begin
        if (anyGrant[j]) begin
          // Load, possibly while unloading the previous word
          popReg[j].valid   <= 1'b1;
          popReg[j].payload <= selData[j];
        end else if (popReady[j]) begin
          // Unload with nothing new behind it
          popReg[j].valid <= 1'b0;
        end
      end
    end
  end

  // Outputs come straight from the flops
  always_comb begin
    for (int j = 0; j < `XBAR_NUM_POP; j++) begin
      popValid[j] = popReg[j].valid;
      popData[j]  = popReg[j].payload;
    end
  end

  // ----------------------------------------------------------------------
  // Push ready
  // ----------------------------------------------------------------------

  // A push is accepted when any pop flow grants it
  always_comb begin
    pushReady = '0;
    for (int j = 0; j < `XBAR_NUM_POP; j++) begin
      pushReady = pushReady | grant[j];
    end
  end

endmodule

`default_nettype wire

// ==== source/flowXbar.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

// Flow-controlled crossbar, fixed priority
// Decoder and arbiter bank side by side, pop stage combines them
module flowXbar
  import xbarPkg::*;
(
  input  wire                                    clk,
  input  wire                                    rstN,

  // Push side
  input  wire flowMaskT                          pushValid,
  input  wire pushFlitT [`XBAR_NUM_PUSH-1:0]     pushFlit,
  output flowMaskT                               pushReady,

  // Pop side
  input  wire logic     [`XBAR_NUM_POP-1:0]      popReady,
  output logic          [`XBAR_NUM_POP-1:0]      popValid,
  output payloadT       [`XBAR_NUM_POP-1:0]      popData
);

  // ----------------------------------------------------------------------
  // Internal wiring
  // ----------------------------------------------------------------------

  // Rows indexed by pop flow
  flowMaskT [`XBAR_NUM_POP-1:0] request;
  flowMaskT [`XBAR_NUM_POP-1:0] grant;
  logic     [`XBAR_NUM_POP-1:0] canGrant;

  // Requests from valid and destination ID
  xbarDestDecode destDecode (
    .pushValid (pushValid),
    .pushFlit  (pushFlit),
    .request   (request)
  );

  // Fixed-priority grant per pop flow
  xbarArbBank arbBank (
    .request  (request),
    .canGrant (canGrant),
    .grant    (grant)
  );

  // Muxes, pop registers and push ready
  xbarPopStage popStage (
    .clk       (clk),
    .rstN      (rstN),
    .pushFlit  (pushFlit),
    .grant     (grant),
    .popReady  (popReady),
    .canGrant  (canGrant),
    .pushReady (pushReady),
    .popValid  (popValid),
    .popData   (popData)
  );

endmodule

`default_nettype wire

// ==== test/xbarChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

// Watches the crossbar ports and compares against a pop register model
module xbarChecker
  import xbarPkg::*;
(
  input  wire                                clk,
  input  wire                                rstN,
  input  wire flowMaskT                      pushValid,
  input  wire pushFlitT [`XBAR_NUM_PUSH-1:0] pushFlit,
  input  wire flowMaskT                      pushReady,
  input  wire logic     [`XBAR_NUM_POP-1:0]  popReady,
  input  wire logic     [`XBAR_NUM_POP-1:0]  popValid,
  input  wire payloadT  [`XBAR_NUM_POP-1:0]  popData,
  output int                                 errorCount,
  output int                                 popCount
);

  localparam int NumPop = `XBAR_NUM_POP;
  localparam int NumPairs = `XBAR_NUM_PUSH * `XBAR_NUM_POP;

  // Expected words per source and destination, index src * NumPop + dst
  payloadT expQ [NumPairs][$];

  // Occupancy model and the source of each held word
  logic [NumPop-1:0] modelValid;
  int modelSrc [NumPop];

  // Checks that look one cycle ahead
  logic [NumPop-1:0] holdPending;
  payloadT holdData [NumPop];
  logic [NumPop-1:0] latPending;
  payloadT latData [NumPop];

  task automatic reportMismatch(input string testName, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    $display("MISMATCH %s expected %h actual %h", testName, expVal, actVal);
    errorCount++;
  endtask

  // Number of source and destination pairs with words never popped
  function automatic int countLost();
    int lost;
    lost = 0;
    for (int p = 0; p < NumPairs; p++) begin
      if (expQ[p].size() != 0) begin
        $display("lost transfers: %0d words from push flow %0d to pop flow %0d",
                 expQ[p].size(), p / NumPop, p % NumPop);
        lost++;
      end
    end
    return lost;
  endfunction

  // ----------------------------------------------------------------------
  // Per-cycle checks, all sampled at the rising edge
  // ----------------------------------------------------------------------

  always @(posedge clk) begin
    flowMaskT expReady;
    logic [NumPop-1:0] loaded;
    payloadT expWord;
    int dst;
    int src;
    if (!rstN) begin
      modelValid  = '0;
      holdPending = '0;
      latPending  = '0;
      errorCount  = 0;
      popCount    = 0;
      for (int j = 0; j < NumPop; j++) begin
        modelSrc[j] = 0;
      end
      for (int p = 0; p < NumPairs; p++) begin
        expQ[p].delete();
      end
    end else begin
      // Words loaded last cycle and words held under back-pressure
      for (int j = 0; j < NumPop; j++) begin
        if (latPending[j] && !popValid[j]) begin
          $display("latency: pop flow %0d not valid the cycle after a push", j);
          errorCount++;
        end else if (latPending[j] && popData[j] !== latData[j]) begin
          reportMismatch("latency", 32'(latData[j]), 32'(popData[j]));
        end
        if (holdPending[j] && !popValid[j]) begin
          $display("back-pressure: pop flow %0d dropped valid while stalled", j);
          errorCount++;
        end else if (holdPending[j] && popData[j] !== holdData[j]) begin
          reportMismatch("back-pressure", 32'(holdData[j]), 32'(popData[j]));
        end
      end
      // Pop valid follows the model, low right after reset
      if (popValid !== modelValid) begin
        reportMismatch("popValid", 32'(modelValid), 32'(popValid));
      end
      // Lowest-indexed requester wins where the register can take a word
      expReady = '0;
      for (int i = 0; i < `XBAR_NUM_PUSH; i++) begin
        dst = int'(pushFlit[i].destId);
        if (pushValid[i] && (!modelValid[dst] || popReady[dst])) begin
          expReady[i] = 1'b1;
          for (int k = 0; k < i; k++) begin
            if (pushValid[k] && pushFlit[k].destId == pushFlit[i].destId) begin
              expReady[i] = 1'b0;
            end
          end
        end
      end
      if (pushReady !== expReady) begin
        reportMismatch("arbitration", 32'(expReady), 32'(pushReady));
      end
      // Unloads before loads, the popped word is always the older one
      for (int j = 0; j < NumPop; j++) begin
        holdPending[j] = popValid[j] && !popReady[j];
        holdData[j]    = popData[j];
        if (popValid[j] && popReady[j]) begin
          popCount++;
          src = modelSrc[j];
          if (expQ[src * NumPop + j].size() == 0) begin
            $display("data: pop flow %0d delivered a word that was never pushed", j);
            errorCount++;
          end else begin
            expWord = expQ[src * NumPop + j].pop_front();
            if (popData[j] !== expWord) begin
              reportMismatch("data", 32'(expWord), 32'(popData[j]));
            end
          end
        end
      end
      loaded     = '0;
      latPending = '0;
      for (int i = 0; i < `XBAR_NUM_PUSH; i++) begin
        if (pushValid[i] && pushReady[i]) begin
          dst = int'(pushFlit[i].destId);
          expQ[i * NumPop + dst].push_back(pushFlit[i].payload);
          modelSrc[dst]   = i;
          latPending[dst] = 1'b1;
          latData[dst]    = pushFlit[i].payload;
          loaded[dst]     = 1'b1;
        end
      end
      // Next occupancy of each pop register
      for (int j = 0; j < NumPop; j++) begin
        if (loaded[j]) begin
          modelValid[j] = 1'b1;
        end else if (popReady[j]) begin
          modelValid[j] = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/xbarTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

module xbarTb
  import xbarPkg::*;
;

  localparam logic [31:0] Seed = 32'h9bae18a4;
  localparam int TimeoutSlack = 100;

  logic clk;
  logic rstN;
  flowMaskT pushValid;
  pushFlitT [`XBAR_NUM_PUSH-1:0] pushFlit;
  flowMaskT pushReady;
  logic [`XBAR_NUM_POP-1:0] popReady;
  logic [`XBAR_NUM_POP-1:0] popValid;
  payloadT [`XBAR_NUM_POP-1:0] popData;

  // Pending transfers per source flow
  // Head of each queue is the word on the bus
  pushFlitT srcQ [`XBAR_NUM_PUSH][$];
  int gap [`XBAR_NUM_PUSH];
  flowMaskT accepted;
  logic running;
  logic [31:0] rngState;
  int total;
  int tbErrors;
  int chkErrors;
  int popsSeen;

  flowXbar uut (
    .clk       (clk),
    .rstN      (rstN),
    .pushValid (pushValid),
    .pushFlit  (pushFlit),
    .pushReady (pushReady),
    .popReady  (popReady),
    .popValid  (popValid),
    .popData   (popData)
  );

  // Reference model and comparisons
  xbarChecker chk (
    .clk        (clk),
    .rstN       (rstN),
    .pushValid  (pushValid),
    .pushFlit   (pushFlit),
    .pushReady  (pushReady),
    .popReady   (popReady),
    .popValid   (popValid),
    .popData    (popData),
    .errorCount (chkErrors),
    .popCount   (popsSeen)
  );

  // LCG step with the usual 32-bit constants
  function automatic logic [31:0] nextRandom(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Handshakes seen at the rising edge
  always @(posedge clk) begin
    accepted <= pushValid & pushReady;
  end

  // ----------------------------------------------------------------------
  // Push drivers and pop ready on the falling edge
  // ----------------------------------------------------------------------

  always @(negedge clk) begin
    int r;
    if (running) begin
      for (int i = 0; i < `XBAR_NUM_PUSH; i++) begin
        if (pushValid[i] && accepted[i]) begin
          void'(srcQ[i].pop_front());
          pushValid[i] = 1'b0;
          rngState = nextRandom(rngState);
          gap[i] = rngState[16] ? 1 : 0;
        end
        // Gap of zero presents the next word right away
        if (!pushValid[i]) begin
          if (gap[i] > 0) begin
            gap[i]--;
          end else if (srcQ[i].size() > 0) begin
            pushValid[i] = 1'b1;
            pushFlit[i]  = srcQ[i][0];
          end
        end
      end
      // Pop ready high about 70% of the time
      for (int j = 0; j < `XBAR_NUM_POP; j++) begin
        rngState = nextRandom(rngState);
        r = int'(rngState[31:16]) % 10;
        popReady[j] = (r < 7);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    int fd;
    int n;
    int src;
    int dst;
    int cycles;
    int limit;
    int lost;
    int totalErrors;
    payloadT data;
    pushFlitT flit;
    string line;
    rstN = 1'b0;
    pushValid = '0;
    pushFlit = '0;
    popReady = '0;
    running = 1'b0;
    rngState = Seed;
    total = 0;
    tbErrors = 0;
    for (int i = 0; i < `XBAR_NUM_PUSH; i++) begin
      gap[i] = 0;
    end
    fd = $fopen("test/xbar_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open test/xbar_testdata.txt");
      tbErrors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // Skip blank lines and comment lines starting with #
        if (line.len() > 1 && line.getc(0) != 8'h23) begin
          n = $sscanf(line, "%d %d %h", src, dst, data);
          if (n == 3 && src >= 0 && src < `XBAR_NUM_PUSH && dst >= 0 && dst < `XBAR_NUM_POP) begin
            flit.payload = data;
            flit.destId  = destIdT'(dst);
            srcQ[src].push_back(flit);
            total++;
          end else begin
            $display("malformed line in test data: %s", line);
            tbErrors++;
          end
        end
      end
      $fclose(fd);
    end
    limit = total * 8 + TimeoutSlack;
    // Reset held low over five rising edges
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    @(posedge clk);
    running = 1'b1;
    cycles = 0;
    while (popsSeen < total && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (popsSeen < total) begin
      $display("timeout: transfers still outstanding");
      tbErrors++;
    end
    repeat (2) @(negedge clk);
    lost = chk.countLost();
    totalErrors = chkErrors + tbErrors + lost;
    $display("errors: %0d checker, %0d testbench, %0d lost, %0d total (%0d of %0d popped)",
             chkErrors, tbErrors, lost, totalErrors, popsSeen, total);
    if (totalErrors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flowXbar.f ====
+incdir+source
source/xbarPkg.sv
source/xbarDestDecode.sv
source/xbarArbBank.sv
source/xbarPopStage.sv
source/flowXbar.sv
test/xbarChecker.sv
test/xbarTb.sv

// ==== Makefile ====
# Verilator simulation of the crossbar testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= xbarTb
FILELIST  ?= flowXbar.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Test completed successfully

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/xbar_testdata.txt ====
# Columns: source push flow (0-3), destination pop flow (0-3), payload (hex)
# Bursts where all four sources aim at one destination exercise fixed priority
0 0 1000
1 1 2000
2 2 3000
3 3 4000
0 1 1001
1 2 2001
2 3 3001
3 0 4001
0 2 1002
1 2 2002
2 2 3002
3 2 4002
0 2 1003
1 2 2003
2 2 3003
3 2 4003
0 0 1004
1 0 2004
2 0 3004
3 0 4004
0 3 1005
1 3 2005
2 3 3005
3 3 4005
0 1 1006
1 0 2006
2 1 3006
3 2 4006
0 3 1007
1 1 2007
2 0 3007
3 1 4007
0 0 1008
1 3 2008
2 2 3008
3 3 4008
0 2 1009
1 2 2009
2 1 3009
3 0 4009
0 1 100a
1 1 200a
2 1 300a
3 1 400a
0 3 100b
2 0 300b
